/* hdl/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path width
`define CPU_WORD_W 32

// general purpose registers, $0 included
`define CPU_REG_NUM 32

`define CPU_ZERO_WORD {`CPU_WORD_W{1'b0}}

// JAL puts its return address here
`define CPU_LINK_REG 5'd31

// one sweep cycle per register after reset
`define CPU_CLEAR_CYCLES `CPU_REG_NUM

`endif

/* hdl/cpu_isa_pkg.sv */
`include "cpu_settings.svh"

package cpu_isa_pkg;

	typedef logic [`CPU_WORD_W-1:0] Word_t;
	typedef logic [15:0] HalfWord_t;
	typedef logic [`CPU_WORD_W-1:0] InstAddr_t;
	typedef logic [31:0] Inst_t;
	typedef logic [$clog2(`CPU_REG_NUM)-1:0] RegAddr_t;
	typedef logic Bit_t;

	// operation handed to EX, one word wide
	typedef enum logic [`CPU_WORD_W-1:0] {
		OP_INVALID,
		OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
		OP_LW, OP_SW,
		OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT,
		OP_MOVZ, OP_MOVN,
		OP_J, OP_JAL
	} Oper_t;

	// primary opcodes, inst[31:26]
	localparam logic [5:0] OPC_SPECIAL = 6'b000000;
	localparam logic [5:0] OPC_J       = 6'b000010;
	localparam logic [5:0] OPC_JAL     = 6'b000011;
	localparam logic [5:0] OPC_ADDI    = 6'b001000;
	localparam logic [5:0] OPC_ADDIU   = 6'b001001;
	localparam logic [5:0] OPC_SLTI    = 6'b001010;
	localparam logic [5:0] OPC_SLTIU   = 6'b001011;
	localparam logic [5:0] OPC_ANDI    = 6'b001100;
	localparam logic [5:0] OPC_ORI     = 6'b001101;
	localparam logic [5:0] OPC_XORI    = 6'b001110;
	localparam logic [5:0] OPC_LUI     = 6'b001111;
	localparam logic [5:0] OPC_LW      = 6'b100011;
	localparam logic [5:0] OPC_SW      = 6'b101011;

	// SPECIAL function codes, inst[5:0]
	localparam logic [5:0] FN_MOVZ = 6'b001010;
	localparam logic [5:0] FN_MOVN = 6'b001011;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_SLT  = 6'b101010;

endpackage

/* hdl/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	// fetched word and where it came from
	typedef struct packed {
		InstAddr_t pc;
		Inst_t     inst;
	} fetch_t;

	typedef struct packed {
		Bit_t     we;
		RegAddr_t waddr;
		Word_t    wdata;
	} RegWriteReq_t;

	// memory request of the instruction now in EX
	typedef struct packed {
		Bit_t ce;
		Bit_t we;
	} MemAccessReq_t;

	// decoded bundle for EX
	typedef struct packed {
		Oper_t     op;
		Word_t     reg1;
		Word_t     reg2;
		Word_t     imm;
		Bit_t      we;
		RegAddr_t  waddr;
		InstAddr_t pc;
	} id_ex_t;

endpackage

/* hdl/id_type_i.sv */
`timescale 1ns/1ps

module id_type_i (
	input  cpu_isa_pkg::Inst_t    inst_i,
	output cpu_isa_pkg::Oper_t    op_o,
	output cpu_isa_pkg::RegAddr_t reg_raddr1_o,
	output cpu_isa_pkg::RegAddr_t reg_raddr2_o,
	output cpu_isa_pkg::RegAddr_t reg_waddr_o,
	output cpu_isa_pkg::Bit_t     reg_we_o,
	output cpu_isa_pkg::Bit_t     unsigned_imm_o
);

	import cpu_isa_pkg::*;

	logic [5:0] opcode;
	RegAddr_t rs, rt;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];

	// most immediate forms read rs and write rt
	always_comb begin
		op_o           = OP_INVALID;
		reg_raddr1_o   = rs;
		reg_raddr2_o   = '0;
		reg_waddr_o    = rt;
		reg_we_o       = 1'b1;
		unsigned_imm_o = 1'b0;
		case (opcode)
			OPC_ORI: begin
				op_o           = OP_ORI;
				unsigned_imm_o = 1'b1;
			end
			OPC_ANDI: begin
				op_o           = OP_ANDI;
				unsigned_imm_o = 1'b1;
			end
			OPC_XORI: begin
				op_o           = OP_XORI;
				unsigned_imm_o = 1'b1;
			end
			// lui ignores rs
			OPC_LUI: begin
				op_o           = OP_LUI;
				reg_raddr1_o   = '0;
				unsigned_imm_o = 1'b1;
			end
			OPC_ADDI:  op_o = OP_ADDI;
			OPC_ADDIU: op_o = OP_ADDIU;
			OPC_SLTI:  op_o = OP_SLTI;
			OPC_SLTIU: op_o = OP_SLTIU;
			OPC_LW:    op_o = OP_LW;
			// store data comes from rt, nothing written back
			OPC_SW: begin
				op_o         = OP_SW;
				reg_raddr2_o = rt;
				reg_we_o     = 1'b0;
			end
			default: begin
				reg_raddr1_o = '0;
				reg_waddr_o  = '0;
				reg_we_o     = 1'b0;
			end
		endcase
	end

endmodule

/* hdl/id_type_r.sv */
`timescale 1ns/1ps

module id_type_r (
	input  cpu_isa_pkg::Inst_t    inst_i,
	output cpu_isa_pkg::Oper_t    op_o,
	output cpu_isa_pkg::RegAddr_t reg_raddr1_o,
	output cpu_isa_pkg::RegAddr_t reg_raddr2_o,
	output cpu_isa_pkg::RegAddr_t reg_waddr_o,
	output cpu_isa_pkg::Bit_t     reg_we_o
);

	import cpu_isa_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	Bit_t is_valid;

	assign opcode = inst_i[31:26];
	assign funct  = inst_i[5:0];

	always_comb begin
		op_o = OP_INVALID;
		if (opcode == OPC_SPECIAL) begin
			case (funct)
				FN_ADDU: op_o = OP_ADDU;
				FN_SUBU: op_o = OP_SUBU;
				FN_AND:  op_o = OP_AND;
				FN_OR:   op_o = OP_OR;
				FN_XOR:  op_o = OP_XOR;
				FN_SLT:  op_o = OP_SLT;
				FN_MOVZ: op_o = OP_MOVZ;
				FN_MOVN: op_o = OP_MOVN;
				default: op_o = OP_INVALID;
			endcase
		end
	end

	// every supported R form reads rs, rt and writes rd
	assign is_valid     = (op_o != OP_INVALID);
	assign reg_raddr1_o = is_valid ? inst_i[25:21] : '0;
	assign reg_raddr2_o = is_valid ? inst_i[20:16] : '0;
	assign reg_waddr_o  = is_valid ? inst_i[15:11] : '0;
	assign reg_we_o     = is_valid;

endmodule

/* hdl/id_decode.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module id_decode (
	input  cpu_pipe_pkg::fetch_t        inst_i,
	input  cpu_isa_pkg::Word_t          reg1_i,
	input  cpu_isa_pkg::Word_t          reg2_i,
	input  cpu_pipe_pkg::MemAccessReq_t ex_memory_req_i,
	input  cpu_pipe_pkg::RegWriteReq_t  ex_wr_i,
	input  cpu_pipe_pkg::RegWriteReq_t  mem_wr_i,
	output cpu_isa_pkg::RegAddr_t       reg_raddr1_o,
	output cpu_isa_pkg::RegAddr_t       reg_raddr2_o,
	output cpu_pipe_pkg::id_ex_t        dec_o,
	output cpu_isa_pkg::Bit_t           stall_req_o
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [5:0] opcode;
	HalfWord_t immediate;
	Word_t imm_zero_ext, imm_signed_ext, imm_sel;
	Word_t safe_reg1, safe_reg2;
	Oper_t op_type_i, op_type_j, op_type_r;
	RegAddr_t raddr1_i, raddr2_i, waddr_i;
	RegAddr_t raddr1_r, raddr2_r, waddr_r;
	Bit_t we_i, we_r, unsigned_imm;
	Bit_t is_i, is_j, is_r;
	Bit_t is_ex_load, cond_move_fail;

	// newest producer wins: EX, then MEM, then the register file
	function automatic Word_t forward(RegAddr_t addr, Word_t rf_data,
		RegWriteReq_t ex, RegWriteReq_t mem);
		if (addr == '0)
			return `CPU_ZERO_WORD;
		if (ex.we && ex.waddr == addr)
			return ex.wdata;
		if (mem.we && mem.waddr == addr)
			return mem.wdata;
		return rf_data;
	endfunction

	assign opcode         = inst_i.inst[31:26];
	assign immediate      = inst_i.inst[15:0];
	assign imm_zero_ext   = {16'h0, immediate};
	assign imm_signed_ext = {{16{immediate[15]}}, immediate};
	assign imm_sel        = unsigned_imm ? imm_zero_ext : imm_signed_ext;

	id_type_i u_type_i (
		.inst_i         (inst_i.inst),
		.op_o           (op_type_i),
		.reg_raddr1_o   (raddr1_i),
		.reg_raddr2_o   (raddr2_i),
		.reg_waddr_o    (waddr_i),
		.reg_we_o       (we_i),
		.unsigned_imm_o (unsigned_imm)
	);

	id_type_r u_type_r (
		.inst_i       (inst_i.inst),
		.op_o         (op_type_r),
		.reg_raddr1_o (raddr1_r),
		.reg_raddr2_o (raddr2_r),
		.reg_waddr_o  (waddr_r),
		.reg_we_o     (we_r)
	);

	// only J and JAL exist on the jump side
	assign op_type_j = (opcode == OPC_J) ? OP_J : (opcode == OPC_JAL) ? OP_JAL : OP_INVALID;

	// I over J over R
	assign is_i = (op_type_i != OP_INVALID);
	assign is_j = !is_i && (op_type_j != OP_INVALID);
	assign is_r = !is_i && !is_j && (op_type_r != OP_INVALID);

	// read addresses depend on the word alone, kept apart from the data path
	always_comb begin
		reg_raddr1_o = '0;
		reg_raddr2_o = '0;
		if (is_i) begin
			reg_raddr1_o = raddr1_i;
			reg_raddr2_o = raddr2_i;
		end else if (is_r) begin
			reg_raddr1_o = raddr1_r;
			reg_raddr2_o = raddr2_r;
		end
	end

	assign safe_reg1 = forward(reg_raddr1_o, reg1_i, ex_wr_i, mem_wr_i);
	assign safe_reg2 = forward(reg_raddr2_o, reg2_i, ex_wr_i, mem_wr_i);

	// a load in EX has no data yet, so a dependent instruction waits
	assign is_ex_load  = ex_memory_req_i.ce && !ex_memory_req_i.we;
	assign stall_req_o = is_ex_load &&
		((ex_wr_i.waddr == reg_raddr1_o && reg_raddr1_o != '0) ||
		 (ex_wr_i.waddr == reg_raddr2_o && reg_raddr2_o != '0));

	// movz moves when rt is zero, movn when it is not
	assign cond_move_fail = (op_type_r == OP_MOVZ && safe_reg2 != `CPU_ZERO_WORD) ||
		(op_type_r == OP_MOVN && safe_reg2 == `CPU_ZERO_WORD);

	always_comb begin
		dec_o.pc    = inst_i.pc;
		dec_o.reg1  = safe_reg1;
		dec_o.reg2  = safe_reg2;
		dec_o.op    = OP_INVALID;
		dec_o.imm   = `CPU_ZERO_WORD;
		dec_o.we    = 1'b0;
		dec_o.waddr = '0;
		if (is_i) begin
			dec_o.op    = op_type_i;
			dec_o.imm   = imm_sel;
			dec_o.we    = we_i;
			dec_o.waddr = waddr_i;
			// arithmetic immediates take the immediate as operand 2
			if (op_type_i inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) begin
				dec_o.reg2 = imm_sel;
			end
		end else if (is_j) begin
			dec_o.op    = op_type_j;
			dec_o.we    = (op_type_j == OP_JAL);
			dec_o.waddr = `CPU_LINK_REG;
		end else if (is_r) begin
			dec_o.op    = op_type_r;
			dec_o.we    = we_r && !cond_move_fail;
			dec_o.waddr = waddr_r;
		end
	end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regfile (
	input  logic                       clk,
	input  logic                       rst_i,
	input  cpu_isa_pkg::RegAddr_t      raddr1_i,
	input  cpu_isa_pkg::RegAddr_t      raddr2_i,
	input  cpu_pipe_pkg::RegWriteReq_t wr_i,
	input  logic                       clear_i,
	input  cpu_isa_pkg::RegAddr_t      clear_addr_i,
	output cpu_isa_pkg::Word_t         rdata1_o,
	output cpu_isa_pkg::Word_t         rdata2_o
);

	import cpu_isa_pkg::*;

	Word_t regs [`CPU_REG_NUM];

	// the sweep after reset is what initialises the array
	always_ff @(posedge clk) begin
		if (clear_i) begin
			regs[clear_addr_i] <= `CPU_ZERO_WORD;
		end else if (wr_i.we && wr_i.waddr != '0) begin
			regs[wr_i.waddr] <= wr_i.wdata;
		end
	end

	// same-cycle WB write is seen by the reader
	assign rdata1_o = (raddr1_i == '0) ? `CPU_ZERO_WORD :
		(wr_i.we && wr_i.waddr == raddr1_i) ? wr_i.wdata : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? `CPU_ZERO_WORD :
		(wr_i.we && wr_i.waddr == raddr2_i) ? wr_i.wdata : regs[raddr2_i];

	// WB must stay quiet while the sweep owns the write port
	a_no_write_in_clear: assert property (@(posedge clk) disable iff (rst_i)
		!(clear_i && wr_i.we));

endmodule

/* hdl/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  payload_t in_data_i,
	output logic     out_valid_o,
	input  logic     out_ready_i,
	output payload_t out_data_o,
	input  logic     hold_i
);

	logic valid_q;
	payload_t data_q;
	logic accept, drain;

	// hold freezes the slot in both directions
	assign drain      = valid_q && out_ready_i && !hold_i;
	assign in_ready_o = !hold_i && (!valid_q || out_ready_i);
	assign accept     = in_valid_i && in_ready_o;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else if (accept) begin
			valid_q <= 1'b1;
		end else if (drain) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			data_q <= in_data_i;
		end
	end

	assign out_valid_o = valid_q;
	assign out_data_o  = data_q;

	// upstream keeps its word steady until the slot takes it
	a_in_stable: assert property (@(posedge clk) disable iff (rst_i)
		in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i));

endmodule

/* hdl/issue_fsm.sv */
`timescale 1ns/1ps

module issue_fsm (
	input  logic clk,
	input  logic rst_i,
	input  logic clear_done_i,
	input  logic stall_req_i,
	input  logic ifid_valid_i,
	input  logic idex_ready_i,
	output logic clear_o,
	output logic ifid_hold_o,
	output logic idex_load_o,
	output logic fetch_en_o
);

	typedef enum logic {
		ST_CLEAR,
		ST_RUN
	} state_t;

	state_t state_q;

	// the last sweep cycle is also the last CLEAR cycle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= ST_CLEAR;
		end else if (state_q == ST_CLEAR && clear_done_i) begin
			state_q <= ST_RUN;
		end
	end

	assign clear_o = (state_q == ST_CLEAR);

	// if_id may hand on when nothing stalls and id_ex has room
	assign fetch_en_o = (state_q == ST_RUN) && !stall_req_i && idex_ready_i;

	// advance
	assign idex_load_o = fetch_en_o && ifid_valid_i;

	// fetch is shut during CLEAR, a load-use stall keeps the word in if_id
	// and id_ex gets a bubble for as long as it lasts
	assign ifid_hold_o = clear_o || (ifid_valid_i && stall_req_i);

	a_clear_quiet: assert property (@(posedge clk) disable iff (rst_i)
		(state_q == ST_CLEAR) |-> !idex_load_o && !ifid_valid_i);

	a_stall_keeps: assert property (@(posedge clk) disable iff (rst_i)
		(state_q == ST_RUN) && ifid_valid_i && stall_req_i |=> ifid_valid_i);

endmodule

/* hdl/sweep_counter.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module sweep_counter (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  en_i,
	output cpu_isa_pkg::RegAddr_t addr_o,
	output logic                  done_o
);

	import cpu_isa_pkg::*;

	RegAddr_t addr_q;

	// parks on the last address, so done stays up until reset
	assign done_o = (addr_q == RegAddr_t'(`CPU_CLEAR_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			addr_q <= '0;
		end else if (en_i && !done_o) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	assign addr_o = addr_q;

endmodule

/* hdl/id_stage_top.sv */
`timescale 1ns/1ps

module id_stage_top (
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        f_valid_i,
	output logic                        f_ready_o,
	input  cpu_pipe_pkg::fetch_t        f_data_i,
	output logic                        d_valid_o,
	input  logic                        d_ready_i,
	output cpu_pipe_pkg::id_ex_t        d_data_o,
	input  cpu_pipe_pkg::MemAccessReq_t ex_mem_req_i,
	input  cpu_pipe_pkg::RegWriteReq_t  ex_wr_i,
	input  cpu_pipe_pkg::RegWriteReq_t  mem_wr_i,
	input  cpu_pipe_pkg::RegWriteReq_t  wb_wr_i
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	fetch_t ifid_data;
	id_ex_t dec;
	RegAddr_t raddr1, raddr2, clear_addr;
	Word_t rdata1, rdata2;
	logic ifid_valid, ifid_hold, fetch_en;
	logic idex_load, idex_ready;
	logic stall_req, clear, clear_done;

	pipe_reg #(.payload_t(fetch_t)) if_id (
		.clk, .rst_i,
		.in_valid_i  (f_valid_i),
		.in_ready_o  (f_ready_o),
		.in_data_i   (f_data_i),
		.out_valid_o (ifid_valid),
		.out_ready_i (fetch_en),
		.out_data_o  (ifid_data),
		.hold_i      (ifid_hold)
	);

	id_decode u_decode (
		.inst_i (ifid_data), .reg1_i (rdata1), .reg2_i (rdata2),
		.ex_memory_req_i (ex_mem_req_i), .ex_wr_i, .mem_wr_i,
		.reg_raddr1_o (raddr1), .reg_raddr2_o (raddr2),
		.dec_o (dec), .stall_req_o (stall_req)
	);

	regfile u_regfile (
		.clk, .rst_i,
		.raddr1_i (raddr1), .raddr2_i (raddr2), .wr_i (wb_wr_i),
		.clear_i (clear), .clear_addr_i (clear_addr),
		.rdata1_o (rdata1), .rdata2_o (rdata2)
	);

	sweep_counter u_sweep (
		.clk, .rst_i, .en_i (clear), .addr_o (clear_addr), .done_o (clear_done)
	);

	issue_fsm u_issue (
		.clk, .rst_i,
		.clear_done_i (clear_done), .stall_req_i (stall_req),
		.ifid_valid_i (ifid_valid), .idex_ready_i (idex_ready),
		.clear_o (clear), .ifid_hold_o (ifid_hold),
		.idex_load_o (idex_load), .fetch_en_o (fetch_en)
	);

	pipe_reg #(.payload_t(id_ex_t)) id_ex (
		.clk, .rst_i,
		.in_valid_i  (idex_load),
		.in_ready_o  (idex_ready),
		.in_data_i   (dec),
		.out_valid_o (d_valid_o),
		.out_ready_i (d_ready_i),
		.out_data_o  (d_data_o),
		.hold_i      (clear)
	);

endmodule

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_id_stage;

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int N_RAND = 60;
	localparam int N_STREAM = 40;
	localparam int N_B2B = 8;
	// all instructions and register writes of the run, with margin
	localparam int MAX_INST = 240;

	localparam logic [5:0] OPC_LIST [12] = '{OPC_ORI, OPC_ANDI, OPC_XORI, OPC_LUI,
		OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_LW, OPC_SW, OPC_J, OPC_JAL};
	// last entry is an unsupported SPECIAL function
	localparam logic [5:0] FN_LIST [9] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
		FN_SLT, FN_MOVZ, FN_MOVN, 6'b000000};

	logic clk;
	logic rst_i;
	logic f_valid_i;
	logic f_ready_o;
	fetch_t f_data_i;
	logic d_valid_o;
	logic d_ready_i;
	id_ex_t d_data_o;
	MemAccessReq_t ex_mem_req_i;
	RegWriteReq_t ex_wr_i;
	RegWriteReq_t mem_wr_i;
	RegWriteReq_t wb_wr_i;

	integer seed = 79409;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycle = 0;
	int start_err;
	Word_t model_regs [`CPU_REG_NUM];
	id_ex_t exp_q [$];
	int acc_q [$];
	fetch_t stream_q [$];
	Word_t pc_next = 32'h0040_0000;

	id_stage_top dut (
		.clk          (clk),
		.rst_i        (rst_i),
		.f_valid_i    (f_valid_i),
		.f_ready_o    (f_ready_o),
		.f_data_i     (f_data_i),
		.d_valid_o    (d_valid_o),
		.d_ready_i    (d_ready_i),
		.d_data_o     (d_data_o),
		.ex_mem_req_i (ex_mem_req_i),
		.ex_wr_i      (ex_wr_i),
		.mem_wr_i     (mem_wr_i),
		.wb_wr_i      (wb_wr_i)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	initial begin
		#((MAX_INST * 40 + 2 * `CPU_CLEAR_CYCLES + 8) * CLK_PERIOD);
		$display("timeout: the run did not complete in the expected time");
		$display("SIMULATION FAILED");
		$finish;
	end

	// operand as EX would see it, newest producer first
	function automatic Word_t operand(RegAddr_t a);
		if (a == 5'd0)
			return '0;
		if (ex_wr_i.we && ex_wr_i.waddr == a)
			return ex_wr_i.wdata;
		if (mem_wr_i.we && mem_wr_i.waddr == a)
			return mem_wr_i.wdata;
		return model_regs[a];
	endfunction

	function automatic Oper_t expected_op(logic [5:0] opc, logic [5:0] fn);
		case (opc)
			OPC_ORI:   return OP_ORI;
			OPC_ANDI:  return OP_ANDI;
			OPC_XORI:  return OP_XORI;
			OPC_LUI:   return OP_LUI;
			OPC_ADDI:  return OP_ADDI;
			OPC_ADDIU: return OP_ADDIU;
			OPC_SLTI:  return OP_SLTI;
			OPC_SLTIU: return OP_SLTIU;
			OPC_LW:    return OP_LW;
			OPC_SW:    return OP_SW;
			OPC_J:     return OP_J;
			OPC_JAL:   return OP_JAL;
			OPC_SPECIAL: begin
				case (fn)
					FN_ADDU: return OP_ADDU;
					FN_SUBU: return OP_SUBU;
					FN_AND:  return OP_AND;
					FN_OR:   return OP_OR;
					FN_XOR:  return OP_XOR;
					FN_SLT:  return OP_SLT;
					FN_MOVZ: return OP_MOVZ;
					FN_MOVN: return OP_MOVN;
					default: return OP_INVALID;
				endcase
			end
			default: return OP_INVALID;
		endcase
	endfunction

	function automatic id_ex_t predict(fetch_t f);
		id_ex_t e;
		RegAddr_t rs;
		RegAddr_t rt;
		Word_t sext;
		Word_t zext;
		rs = f.inst[25:21];
		rt = f.inst[20:16];
		sext = {{16{f.inst[15]}}, f.inst[15:0]};
		zext = {16'h0000, f.inst[15:0]};
		e = '0;
		e.pc = f.pc;
		e.op = expected_op(f.inst[31:26], f.inst[5:0]);
		case (e.op)
			OP_ORI, OP_ANDI, OP_XORI: begin
				e.reg1 = operand(rs);
				e.imm = zext;
				e.we = 1'b1;
				e.waddr = rt;
			end
			// lui has no register source
			OP_LUI: begin
				e.imm = zext;
				e.we = 1'b1;
				e.waddr = rt;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				e.reg1 = operand(rs);
				e.imm = sext;
				e.reg2 = sext;
				e.we = 1'b1;
				e.waddr = rt;
			end
			OP_LW: begin
				e.reg1 = operand(rs);
				e.imm = sext;
				e.we = 1'b1;
				e.waddr = rt;
			end
			OP_SW: begin
				e.reg1 = operand(rs);
				e.reg2 = operand(rt);
				e.imm = sext;
			end
			OP_J, OP_INVALID: begin
			end
			OP_JAL: begin
				e.we = 1'b1;
				e.waddr = `CPU_LINK_REG;
			end
			default: begin
				e.reg1 = operand(rs);
				e.reg2 = operand(rt);
				e.we = 1'b1;
				e.waddr = f.inst[15:11];
				if (e.op == OP_MOVZ)
					e.we = (e.reg2 == '0);
				if (e.op == OP_MOVN)
					e.we = (e.reg2 != '0);
			end
		endcase
		return e;
	endfunction

	function automatic fetch_t make_r(logic [5:0] fn, RegAddr_t rd, RegAddr_t rs, RegAddr_t rt);
		fetch_t f;
		f.pc = pc_next;
		f.inst = {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
		pc_next = pc_next + 32'd4;
		return f;
	endfunction

	function automatic fetch_t random_inst();
		fetch_t f;
		int pick;
		pick = {$random(seed)} % 22;
		f.pc = $random(seed);
		f.inst = $random(seed);
		// small register numbers so sources hit earlier writes
		f.inst[25:21] = {2'b00, 3'($random(seed))};
		f.inst[20:16] = {2'b00, 3'($random(seed))};
		f.inst[15:11] = {2'b00, 3'($random(seed))};
		if (pick < 12) begin
			f.inst[31:26] = OPC_LIST[pick];
		end else if (pick < 21) begin
			f.inst[31:26] = OPC_SPECIAL;
			f.inst[5:0] = FN_LIST[pick - 12];
		end else begin
			f.inst[31:26] = 6'b000100;
		end
		return f;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_dec(input id_ex_t got, input id_ex_t exp);
		check_val("d_data_o.op", 32'(got.op), 32'(exp.op));
		check_val("d_data_o.reg1", got.reg1, exp.reg1);
		check_val("d_data_o.reg2", got.reg2, exp.reg2);
		check_val("d_data_o.imm", got.imm, exp.imm);
		check_val("d_data_o.we", 32'(got.we), 32'(exp.we));
		// the address only matters when something is written
		if (exp.we)
			check_val("d_data_o.waddr", 32'(got.waddr), 32'(exp.waddr));
		check_val("d_data_o.pc", got.pc, exp.pc);
	endtask

	task automatic apply_reset();
		rst_i = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
	endtask

	task automatic wb_write(input RegAddr_t a, input Word_t d);
		wb_wr_i = '{1'b1, a, d};
		@(negedge clk);
		wb_wr_i = '0;
		if (a != 5'd0)
			model_regs[a] = d;
	endtask

	// one instruction through both ports, latency counted in edges
	task automatic run_one(input fetch_t f, input id_ex_t exp, output int lat);
		logic acc;
		logic done;
		id_ex_t got;
		f_valid_i = 1'b1;
		f_data_i = f;
		acc = 1'b0;
		while (!acc) begin
			#15;
			acc = f_ready_o;
			@(negedge clk);
		end
		f_valid_i = 1'b0;
		lat = 1;
		done = 1'b0;
		while (!done) begin
			#15;
			done = d_valid_o && d_ready_i;
			got = d_data_o;
			@(negedge clk);
			if (!done)
				lat++;
		end
		check_dec(got, exp);
	endtask

	task automatic stream_run(input int n, input bit backpressure);
		int got_n;
		int lat;
		logic acc;
		stream_q.delete();
		for (int i = 0; i < n; i++) begin
			stream_q.push_back(random_inst());
			exp_q.push_back(predict(stream_q[i]));
		end
		fork
			begin
				for (int i = 0; i < n; i++) begin
					f_valid_i = 1'b1;
					f_data_i = stream_q[i];
					acc = 1'b0;
					while (!acc) begin
						#15;
						acc = f_ready_o;
						if (acc)
							acc_q.push_back(cycle + 1);
						@(negedge clk);
					end
				end
				f_valid_i = 1'b0;
			end
			begin
				got_n = 0;
				while (got_n < n) begin
					d_ready_i = backpressure ? (({$random(seed)} % 4) != 0) : 1'b1;
					#15;
					if (d_valid_o && d_ready_i) begin
						check_dec(d_data_o, exp_q.pop_front());
						lat = cycle + 1 - acc_q.pop_front();
						if (!backpressure)
							check_val("d_valid_o latency", lat, 2);
						got_n++;
					end
					@(negedge clk);
				end
				d_ready_i = 1'b1;
			end
		join
		// nothing may trail the last expected instruction
		repeat (3) begin
			#15;
			checks++;
			assert (!d_valid_o) else begin
				$display("extra instruction left the stage at t=%0t", $time);
				errors++;
			end
			@(negedge clk);
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == start_err)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - start_err);
		start_err = errors;
	endtask

	initial begin
		fetch_t f;
		id_ex_t e;
		int lat;
		int low;
		rst_i = 1'b1;
		f_valid_i = 1'b0;
		f_data_i = '0;
		d_ready_i = 1'b1;
		ex_mem_req_i = '0;
		ex_wr_i = '0;
		mem_wr_i = '0;
		wb_wr_i = '0;
		start_err = 0;
		apply_reset();

		// let the first sweep finish, then dirty every register for the next one
		wait (f_ready_o);
		@(negedge clk);
		for (int r = 1; r < `CPU_REG_NUM; r++)
			wb_write(RegAddr_t'(r), ~Word_t'(r));
		apply_reset();
		// the sweep after reset should leave every register at zero
		for (int r = 0; r < `CPU_REG_NUM; r++)
			model_regs[r] = '0;

		low = 0;
		#15;
		while (!f_ready_o && low < 100) begin
			low++;
			@(negedge clk);
			#15;
		end
		@(negedge clk);
		check_val("f_ready_o low cycles", low, `CPU_CLEAR_CYCLES);
		for (int r = 0; r < `CPU_REG_NUM; r++) begin
			f = make_r(FN_OR, 5'd1, RegAddr_t'(r), RegAddr_t'(r));
			run_one(f, predict(f), lat);
		end
		report_test("clear sweep");

		for (int r = 1; r < 8; r++)
			wb_write(RegAddr_t'(r), $random(seed));
		for (int i = 0; i < N_RAND; i++) begin
			f = random_inst();
			run_one(f, predict(f), lat);
		end
		report_test("random decode");

		wb_write(5'd5, 32'h1111_1111);
		wb_write(5'd6, 32'h2222_2222);
		ex_wr_i = '{1'b1, 5'd5, 32'haaaa_0001};
		mem_wr_i = '{1'b1, 5'd5, 32'hbbbb_0001};
		f = make_r(FN_ADDU, 5'd2, 5'd5, 5'd5);
		run_one(f, predict(f), lat);
		ex_wr_i = '{1'b1, 5'd6, 32'haaaa_0002};
		f = make_r(FN_SUBU, 5'd2, 5'd5, 5'd6);
		run_one(f, predict(f), lat);
		ex_wr_i = '{1'b0, 5'd5, 32'haaaa_0003};
		mem_wr_i = '{1'b0, 5'd5, 32'hbbbb_0003};
		f = make_r(FN_XOR, 5'd2, 5'd5, 5'd6);
		run_one(f, predict(f), lat);
		ex_wr_i = '{1'b1, 5'd0, 32'haaaa_0004};
		mem_wr_i = '{1'b1, 5'd0, 32'hbbbb_0004};
		f = make_r(FN_OR, 5'd2, 5'd0, 5'd0);
		run_one(f, predict(f), lat);
		ex_wr_i = '0;
		mem_wr_i = '0;
		report_test("forwarding");

		// load in EX writes $5, its data shows up in MEM once the stall clears
		f = make_r(FN_ADDU, 5'd3, 5'd5, 5'd6);
		mem_wr_i = '{1'b1, 5'd5, 32'h0bad_cafe};
		e = predict(f);
		mem_wr_i = '0;
		ex_mem_req_i = '{1'b1, 1'b0};
		ex_wr_i = '{1'b0, 5'd5, 32'h0};
		fork
			run_one(f, e, lat);
			begin
				repeat (4) @(negedge clk);
				ex_mem_req_i = '0;
				ex_wr_i = '0;
				mem_wr_i = '{1'b1, 5'd5, 32'h0bad_cafe};
			end
		join
		check_val("stalled latency", lat, 5);
		mem_wr_i = '0;
		ex_mem_req_i = '{1'b1, 1'b0};
		ex_wr_i = '{1'b0, 5'd9, 32'h0};
		f = make_r(FN_AND, 5'd3, 5'd5, 5'd6);
		run_one(f, predict(f), lat);
		check_val("independent latency", lat, 2);
		ex_mem_req_i = '0;
		ex_wr_i = '0;
		report_test("load-use stall");

		wb_write(5'd8, 32'h0);
		wb_write(5'd9, 32'h0000_5a5a);
		f = make_r(FN_MOVZ, 5'd4, 5'd1, 5'd8);
		run_one(f, predict(f), lat);
		f = make_r(FN_MOVZ, 5'd4, 5'd1, 5'd9);
		run_one(f, predict(f), lat);
		f = make_r(FN_MOVN, 5'd4, 5'd1, 5'd8);
		run_one(f, predict(f), lat);
		f = make_r(FN_MOVN, 5'd4, 5'd1, 5'd9);
		run_one(f, predict(f), lat);
		report_test("conditional move");

		stream_run(N_STREAM, 1'b1);
		stream_run(N_B2B, 1'b0);
		report_test("back-pressure");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hdl
hdl/cpu_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/id_type_i.sv
hdl/id_type_r.sv
hdl/id_decode.sv
hdl/regfile.sv
hdl/pipe_reg.sv
hdl/issue_fsm.sv
hdl/sweep_counter.sv
hdl/id_stage_top.sv
testbench/tb_id_stage.sv

/* Makefile */
TOP = tb_id_stage

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
